//--- design/mcu_trace_pkg.sv
/*
 * Shared types and DMI register map for the MCU instruction-trace block.
 * Imported by every RTL module of the trace capture path and by the
 * testbench.
 */

package mcu_trace_pkg;

    // Widths that carry a meaning
    localparam int TRACE_WORD_W  = 32;
    localparam int TRACE_FLAGS_W = 2;
    localparam int DMI_ADDR_W    = 7;

    typedef logic [TRACE_WORD_W-1:0]  trace_word_t;
    typedef logic [TRACE_FLAGS_W-1:0] trace_flags_t;
    typedef logic [DMI_ADDR_W-1:0]    dmi_addr_t;

    // Bit positions inside trace_flags_t
    localparam int TRACE_FLAG_EXC = 0;
    localparam int TRACE_FLAG_INT = 1;

    // Bit positions inside the status register
    localparam int STATUS_VALID_BIT   = 0;
    localparam int STATUS_WRAPPED_BIT = 1;

    //////////////////////////////////////////////////
    // DMI register map
    //////////////////////////////////////////////////
    localparam dmi_addr_t DMI_TRACE_STATUS     = 7'h50;
    localparam dmi_addr_t DMI_TRACE_CONFIG     = 7'h51;
    localparam dmi_addr_t DMI_TRACE_WR_PTR     = 7'h52;
    localparam dmi_addr_t DMI_TRACE_RD_PTR     = 7'h53;
    localparam dmi_addr_t DMI_TRACE_DATA_INSN  = 7'h54;
    localparam dmi_addr_t DMI_TRACE_DATA_PC    = 7'h55;
    localparam dmi_addr_t DMI_TRACE_DATA_FLAGS = 7'h56;
    localparam dmi_addr_t DMI_TRACE_COUNT      = 7'h57;

endpackage

//--- design/mcu_trace_capture.sv
/*
 * Trace packet capture stage. Qualifies retired-instruction packets with
 * debug enable, registers the accepted packet with packed flags and issues
 * a one-cycle write strobe to the ring. Also counts accepted packets.
 */

`timescale 1ns/10ps

module mcu_trace_capture
    import mcu_trace_pkg::*;
(
    input  logic         clk,
    input  logic         rst_i,
    input  logic         debug_en_i,
    input  logic         trace_valid_i,
    input  trace_word_t  trace_insn_i,
    input  trace_word_t  trace_pc_i,
    input  logic         trace_exception_i,
    input  logic         trace_interrupt_i,
    output logic         wr_en_o,
    output trace_word_t  insn_o,
    output trace_word_t  pc_o,
    output trace_flags_t flags_o,
    output trace_word_t  count_o
);

    logic accept;

    // Packets are dropped while debug is locked
    assign accept = debug_en_i & trace_valid_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_en_o <= 1'b0;
            count_o <= '0;
        end else begin
            wr_en_o <= accept;
            // Free running, wraps at 2^32
            if (accept) begin
                count_o <= count_o + 1'b1;
            end
        end
    end

    // Packet payload
    always_ff @(posedge clk) begin
        if (accept) begin
            insn_o                  <= trace_insn_i;
            pc_o                    <= trace_pc_i;
            flags_o[TRACE_FLAG_EXC] <= trace_exception_i;
            flags_o[TRACE_FLAG_INT] <= trace_interrupt_i;
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////
    a_strobe_from_accept: assert property (@(posedge clk) disable iff (rst_i)
        wr_en_o |-> $past(debug_en_i && trace_valid_i))
        else $error("trace write strobe without an accepted packet");

endmodule

//--- design/mcu_trace_ring.sv
/*
 * Circular trace storage of TRACE_DEPTH entries. Writes land at the write
 * pointer, which rolls over modulo the depth and sets a sticky wrap flag.
 * Entries are read combinationally at an external index.
 */

`timescale 1ns/10ps

module mcu_trace_ring
    import mcu_trace_pkg::*;
#(
    parameter int  TRACE_DEPTH = 16,
    localparam int PTR_W       = $clog2(TRACE_DEPTH)
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             wr_en_i,
    input  trace_word_t      insn_i,
    input  trace_word_t      pc_i,
    input  trace_flags_t     flags_i,
    input  logic [PTR_W-1:0] rd_idx_i,
    output logic [PTR_W-1:0] wr_ptr_o,
    output logic             wrapped_o,
    output trace_word_t      rd_insn_o,
    output trace_word_t      rd_pc_o,
    output trace_flags_t     rd_flags_o
);

    trace_word_t  insn_mem  [TRACE_DEPTH];
    trace_word_t  pc_mem    [TRACE_DEPTH];
    trace_flags_t flags_mem [TRACE_DEPTH];

    logic last_slot;

    assign last_slot = (wr_ptr_o == PTR_W'(TRACE_DEPTH - 1));

    // Pointer and wrap flag
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_o  <= '0;
            wrapped_o <= 1'b0;
        end else if (wr_en_i) begin
            // Depth is a power of two, so the add rolls over by itself
            wr_ptr_o <= wr_ptr_o + 1'b1;
            if (last_slot) begin
                wrapped_o <= 1'b1;
            end
        end
    end

    // Storage, oldest entry is overwritten once full
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            insn_mem[wr_ptr_o]  <= insn_i;
            pc_mem[wr_ptr_o]    <= pc_i;
            flags_mem[wr_ptr_o] <= flags_i;
        end
    end

    assign rd_insn_o  = insn_mem[rd_idx_i];
    assign rd_pc_o    = pc_mem[rd_idx_i];
    assign rd_flags_o = flags_mem[rd_idx_i];

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////
    a_wrapped_sticky: assert property (@(posedge clk) disable iff (rst_i)
        wrapped_o |=> wrapped_o)
        else $error("trace wrap flag cleared without reset");

endmodule

//--- design/mcu_trace_dmi.sv
/*
 * DMI register port for trace read-back. Holds the writable read pointer,
 * which indexes the ring, and decodes the trace register map into the
 * combinational read data. Unmapped addresses return zero.
 */

`timescale 1ns/10ps

module mcu_trace_dmi
    import mcu_trace_pkg::*;
#(
    parameter int  TRACE_DEPTH = 16,
    localparam int PTR_W       = $clog2(TRACE_DEPTH)
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             dmi_reg_wen_i,
    input  dmi_addr_t        dmi_reg_addr_i,
    input  trace_word_t      dmi_reg_wdata_i,
    input  logic [PTR_W-1:0] wr_ptr_i,
    input  logic             wrapped_i,
    input  trace_word_t      rd_insn_i,
    input  trace_word_t      rd_pc_i,
    input  trace_flags_t     rd_flags_i,
    input  trace_word_t      count_i,
    output trace_word_t      dmi_reg_rdata_o,
    output logic [PTR_W-1:0] rd_idx_o
);

    logic        rd_ptr_wr;
    logic        valid_data;
    trace_word_t status_word;

    assign rd_ptr_wr = dmi_reg_wen_i && (dmi_reg_addr_i == DMI_TRACE_RD_PTR);

    //////////////////////////////////////////////////
    // Read pointer
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_idx_o <= '0;
        end else if (rd_ptr_wr) begin
            // Upper bits dropped, keeps the index modulo depth
            rd_idx_o <= dmi_reg_wdata_i[PTR_W-1:0];
        end
    end

    // Something has been written since reset
    assign valid_data = wrapped_i || (wr_ptr_i != '0);

    always_comb begin
        status_word                     = '0;
        status_word[STATUS_VALID_BIT]   = valid_data;
        status_word[STATUS_WRAPPED_BIT] = wrapped_i;
    end

    //////////////////////////////////////////////////
    // Register decode
    //////////////////////////////////////////////////
    always_comb begin
        case (dmi_reg_addr_i)
            DMI_TRACE_STATUS: begin
                dmi_reg_rdata_o = status_word;
            end
            DMI_TRACE_CONFIG: begin
                dmi_reg_rdata_o = trace_word_t'(TRACE_DEPTH);
            end
            DMI_TRACE_WR_PTR: begin
                dmi_reg_rdata_o = {{(TRACE_WORD_W-PTR_W){1'b0}}, wr_ptr_i};
            end
            DMI_TRACE_RD_PTR: begin
                dmi_reg_rdata_o = {{(TRACE_WORD_W-PTR_W){1'b0}}, rd_idx_o};
            end
            DMI_TRACE_DATA_INSN: begin
                dmi_reg_rdata_o = rd_insn_i;
            end
            DMI_TRACE_DATA_PC: begin
                dmi_reg_rdata_o = rd_pc_i;
            end
            DMI_TRACE_DATA_FLAGS: begin
                dmi_reg_rdata_o = {{(TRACE_WORD_W-TRACE_FLAGS_W){1'b0}}, rd_flags_i};
            end
            DMI_TRACE_COUNT: begin
                dmi_reg_rdata_o = count_i;
            end
            default: begin
                dmi_reg_rdata_o = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////
    // Writes elsewhere in the map are ignored by hardware
    a_wr_only_rd_ptr: assert property (@(posedge clk) disable iff (rst_i)
        dmi_reg_wen_i |-> (dmi_reg_addr_i == DMI_TRACE_RD_PTR))
        else $warning("DMI write to read-only trace register 0x%0h", dmi_reg_addr_i);

endmodule

//--- design/mcu_trace_top.sv
/*
 * MCU instruction-trace top level. Capture feeds the ring buffer, and the
 * DMI register port reads it back. TRACE_DEPTH sets the ring size and must
 * be a power of two of at least 4.
 */

`timescale 1ns/10ps

module mcu_trace_top
    import mcu_trace_pkg::*;
#(
    parameter int TRACE_DEPTH = 16
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        debug_en_i,

    // Retired instruction trace
    input  logic        trace_valid_i,
    input  trace_word_t trace_insn_i,
    input  trace_word_t trace_pc_i,
    input  logic        trace_exception_i,
    input  logic        trace_interrupt_i,

    // DMI register access
    input  logic        dmi_reg_wen_i,
    input  dmi_addr_t   dmi_reg_addr_i,
    input  trace_word_t dmi_reg_wdata_i,
    output trace_word_t dmi_reg_rdata_o
);

    localparam int PTR_W = $clog2(TRACE_DEPTH);

    // Capture to ring
    logic         cap_wr_en;
    trace_word_t  cap_insn;
    trace_word_t  cap_pc;
    trace_flags_t cap_flags;
    trace_word_t  cap_count;

    // Ring to DMI port
    logic [PTR_W-1:0] ring_wr_ptr;
    logic             ring_wrapped;
    trace_word_t      ring_rd_insn;
    trace_word_t      ring_rd_pc;
    trace_flags_t     ring_rd_flags;
    logic [PTR_W-1:0] dmi_rd_idx;

    mcu_trace_capture i_capture (
        .clk               (clk),
        .rst_i             (rst_i),
        .debug_en_i        (debug_en_i),
        .trace_valid_i     (trace_valid_i),
        .trace_insn_i      (trace_insn_i),
        .trace_pc_i        (trace_pc_i),
        .trace_exception_i (trace_exception_i),
        .trace_interrupt_i (trace_interrupt_i),
        .wr_en_o           (cap_wr_en),
        .insn_o            (cap_insn),
        .pc_o              (cap_pc),
        .flags_o           (cap_flags),
        .count_o           (cap_count)
    );

    mcu_trace_ring #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) i_ring (
        .clk        (clk),
        .rst_i      (rst_i),
        .wr_en_i    (cap_wr_en),
        .insn_i     (cap_insn),
        .pc_i       (cap_pc),
        .flags_i    (cap_flags),
        .rd_idx_i   (dmi_rd_idx),
        .wr_ptr_o   (ring_wr_ptr),
        .wrapped_o  (ring_wrapped),
        .rd_insn_o  (ring_rd_insn),
        .rd_pc_o    (ring_rd_pc),
        .rd_flags_o (ring_rd_flags)
    );

    mcu_trace_dmi #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) i_dmi (
        .clk             (clk),
        .rst_i           (rst_i),
        .dmi_reg_wen_i   (dmi_reg_wen_i),
        .dmi_reg_addr_i  (dmi_reg_addr_i),
        .dmi_reg_wdata_i (dmi_reg_wdata_i),
        .wr_ptr_i        (ring_wr_ptr),
        .wrapped_i       (ring_wrapped),
        .rd_insn_i       (ring_rd_insn),
        .rd_pc_i         (ring_rd_pc),
        .rd_flags_i      (ring_rd_flags),
        .count_i         (cap_count),
        .dmi_reg_rdata_o (dmi_reg_rdata_o),
        .rd_idx_o        (dmi_rd_idx)
    );

endmodule

//--- tb/tb_clock_gen.sv
/*
 * Testbench clock and reset source. Makes a 100 ns clock and holds the
 * synchronous reset high for the first five rising edges.
 */

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        // Release on the falling edge, away from the sampling edge
        @(negedge clk_o);
        rst_o = 1'b0;
    end

    always #HALF_PERIOD clk_o = ~clk_o;

endmodule

//--- tb/tb_mcu_trace_tests.svh
/*
 * Directed tests for the trace block, included inside the testbench top.
 * Each task starts and ends on a falling clock edge.
 */

`ifndef TB_MCU_TRACE_TESTS_SVH
`define TB_MCU_TRACE_TESTS_SVH

task automatic test_after_reset();
    trace_word_t rdata;
    dmi_read(DMI_TRACE_STATUS, rdata);
    check_word(rdata, 32'd0, "STATUS after reset");
    dmi_read(DMI_TRACE_WR_PTR, rdata);
    check_word(rdata, 32'd0, "WR_PTR after reset");
    dmi_read(DMI_TRACE_COUNT, rdata);
    check_word(rdata, 32'd0, "COUNT after reset");
    dmi_read(DMI_TRACE_CONFIG, rdata);
    check_word(rdata, 32'd16, "CONFIG");
endtask

task automatic test_capture();
    trace_word_t r;
    for (int i = 0; i < 10; i++) begin
        send_packet(1'b1);
        // Mix of gaps and back-to-back packets
        r = lcg_next();
        if (r[29]) begin
            idle_cycles(1);
        end
    end
    idle_cycles(2);
    check_status();
    for (int i = 0; i < 10; i++) begin
        check_entry(i);
    end
endtask

// Packets with debug off must leave no trace
task automatic test_debug_disabled();
    for (int i = 0; i < 5; i++) begin
        send_packet(1'b0);
    end
    idle_cycles(2);
    check_status();
    for (int i = 0; i < 10; i++) begin
        check_entry(i);
    end
endtask

task automatic test_wrap();
    trace_word_t rdata;
    int          oldest;
    for (int i = 0; i < 20; i++) begin
        send_packet(1'b1);
    end
    idle_cycles(2);
    check_status();
    dmi_read(DMI_TRACE_WR_PTR, rdata);
    check_word(rdata, 32'd14, "WR_PTR after wrap");
    for (int i = 0; i < TRACE_DEPTH; i++) begin
        check_entry(i);
    end
    // Slot at the write pointer holds the oldest surviving packet
    oldest = exp_insn_q.size() - TRACE_DEPTH;
    dmi_write(DMI_TRACE_RD_PTR, 32'd14);
    dmi_read(DMI_TRACE_DATA_INSN, rdata);
    check_word(rdata, exp_insn_q[oldest], "oldest entry at WR_PTR");
endtask

task automatic test_rd_ptr();
    trace_word_t rdata;
    int          pos;
    pos = latest_at(3);
    dmi_write(DMI_TRACE_RD_PTR, 32'd19);
    dmi_read(DMI_TRACE_RD_PTR, rdata);
    check_word(rdata, 32'd3, "RD_PTR modulo depth");
    dmi_read(DMI_TRACE_DATA_INSN, rdata);
    check_word(rdata, exp_insn_q[pos], "first insn read at index 3");
    dmi_read(DMI_TRACE_DATA_INSN, rdata);
    check_word(rdata, exp_insn_q[pos], "second insn read at index 3");
    dmi_read(DMI_TRACE_WR_PTR, rdata);
    check_word(rdata, 32'd14, "WR_PTR after reads");
    dmi_read(7'h10, rdata);
    check_word(rdata, 32'd0, "unmapped address");
endtask

`endif

//--- tb/tb_mcu_trace.sv
/*
 * Testbench top for the MCU trace block. Drives packets and DMI accesses on
 * the falling clock edge, keeps a queue of accepted packets as the expected
 * ring contents and runs the directed tests from the included test file.
 */

`timescale 1ns/10ps

module tb_mcu_trace
    import mcu_trace_pkg::*;
();

    localparam int TRACE_DEPTH    = 16;
    // 10 captured, 5 with debug off, 20 for the wrap
    localparam int NUM_PACKETS    = 35;
    localparam int TIMEOUT_CYCLES = 200 + 4 * NUM_PACKETS;

    logic        clk;
    logic        rst;
    logic        debug_en;
    logic        trace_valid;
    trace_word_t trace_insn;
    trace_word_t trace_pc;
    logic        trace_exc;
    logic        trace_int;
    logic        dmi_wen;
    dmi_addr_t   dmi_addr;
    trace_word_t dmi_wdata;
    trace_word_t dmi_rdata;

    // Every accepted packet, oldest first
    trace_word_t  exp_insn_q  [$];
    trace_word_t  exp_pc_q    [$];
    trace_flags_t exp_flags_q [$];

    trace_word_t lcg_state = 32'd29009;
    int          cycle_count = 0;

    tb_clock_gen i_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    mcu_trace_top #(
        .TRACE_DEPTH (TRACE_DEPTH)
    ) i_dut (
        .clk               (clk),
        .rst_i             (rst),
        .debug_en_i        (debug_en),
        .trace_valid_i     (trace_valid),
        .trace_insn_i      (trace_insn),
        .trace_pc_i        (trace_pc),
        .trace_exception_i (trace_exc),
        .trace_interrupt_i (trace_int),
        .dmi_reg_wen_i     (dmi_wen),
        .dmi_reg_addr_i    (dmi_addr),
        .dmi_reg_wdata_i   (dmi_wdata),
        .dmi_reg_rdata_o   (dmi_rdata)
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic trace_word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Queue position of the newest packet stored at a ring index
    function automatic int latest_at(input int idx);
        int pos;
        pos = -1;
        for (int k = 0; k < exp_insn_q.size(); k++) begin
            if (k % TRACE_DEPTH == idx) begin
                pos = k;
            end
        end
        return pos;
    endfunction

    task automatic fail_run(input string why);
        $display("TESTBENCH FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_word(input trace_word_t got, input trace_word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
            fail_run("trace word mismatch");
        end
    endtask

    task automatic check_flags(input trace_flags_t got, input trace_flags_t exp,
                               input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s read %b, expected %b", $time, what, got, exp);
            fail_run("trace flags mismatch");
        end
    endtask

    // Address set on one falling edge, data taken on the next
    task automatic dmi_read(input dmi_addr_t addr, output trace_word_t data);
        dmi_wen  = 1'b0;
        dmi_addr = addr;
        @(negedge clk);
        data = dmi_rdata;
    endtask

    task automatic dmi_write(input dmi_addr_t addr, input trace_word_t data);
        dmi_wen   = 1'b1;
        dmi_addr  = addr;
        dmi_wdata = data;
        @(negedge clk);
        dmi_wen   = 1'b0;
    endtask

    task automatic send_packet(input logic enabled);
        trace_word_t  r;
        trace_flags_t f;
        r = lcg_next();
        f[TRACE_FLAG_EXC] = r[31];
        f[TRACE_FLAG_INT] = r[30];
        debug_en    = enabled;
        trace_valid = 1'b1;
        trace_insn  = r;
        trace_pc    = lcg_next() & 32'hFFFF_FFFC;
        trace_exc   = f[TRACE_FLAG_EXC];
        trace_int   = f[TRACE_FLAG_INT];
        @(negedge clk);
        if (enabled) begin
            exp_insn_q.push_back(trace_insn);
            exp_pc_q.push_back(trace_pc);
            exp_flags_q.push_back(f);
        end
    endtask

    task automatic idle_cycles(input int n);
        trace_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // Status, write pointer and count as the queue predicts them
    task automatic check_status();
        trace_word_t rdata;
        trace_word_t exp_status;
        int          n;
        n = exp_insn_q.size();
        exp_status = '0;
        exp_status[STATUS_WRAPPED_BIT] = (n >= TRACE_DEPTH);
        exp_status[STATUS_VALID_BIT]   = (n >= TRACE_DEPTH) || (n % TRACE_DEPTH != 0);
        dmi_read(DMI_TRACE_STATUS, rdata);
        check_word(rdata, exp_status, "STATUS");
        dmi_read(DMI_TRACE_WR_PTR, rdata);
        check_word(rdata, trace_word_t'(n % TRACE_DEPTH), "WR_PTR");
        dmi_read(DMI_TRACE_COUNT, rdata);
        check_word(rdata, trace_word_t'(n), "COUNT");
    endtask

    task automatic check_entry(input int idx);
        trace_word_t rdata;
        int          pos;
        pos = latest_at(idx);
        dmi_write(DMI_TRACE_RD_PTR, trace_word_t'(idx));
        dmi_read(DMI_TRACE_DATA_INSN, rdata);
        check_word(rdata, exp_insn_q[pos], $sformatf("insn at index %0d", idx));
        dmi_read(DMI_TRACE_DATA_PC, rdata);
        check_word(rdata, exp_pc_q[pos], $sformatf("pc at index %0d", idx));
        dmi_read(DMI_TRACE_DATA_FLAGS, rdata);
        check_flags(trace_flags_t'(rdata), exp_flags_q[pos],
                    $sformatf("flags at index %0d", idx));
        // Bits above the flags read as zero
        check_word(rdata >> TRACE_FLAGS_W, '0,
                   $sformatf("flags upper bits at index %0d", idx));
    endtask

    `include "tb_mcu_trace_tests.svh"

    //////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            fail_run("timeout");
        end
    end

    initial begin
        debug_en    = 1'b0;
        trace_valid = 1'b0;
        trace_insn  = '0;
        trace_pc    = '0;
        trace_exc   = 1'b0;
        trace_int   = 1'b0;
        dmi_wen     = 1'b0;
        dmi_addr    = '0;
        dmi_wdata   = '0;
        @(posedge clk);
        while (rst) begin
            @(negedge clk);
        end
        test_after_reset();
        test_capture();
        test_debug_disabled();
        test_wrap();
        test_rd_ptr();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- mcu_trace.f
+incdir+tb
design/mcu_trace_pkg.sv
design/mcu_trace_capture.sv
design/mcu_trace_ring.sv
design/mcu_trace_dmi.sv
design/mcu_trace_top.sv
tb/tb_clock_gen.sv
tb/tb_mcu_trace.sv

//--- Makefile
# Verilator simulation of the MCU trace block

TOP     := tb_mcu_trace
OBJ_DIR := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) \
		-f mcu_trace.f
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)
